//--- hw/comp_macros.svh
`ifndef COMP_MACROS_SVH
`define COMP_MACROS_SVH

// stream word width in bits
`define COMP_WORD_W 32

// header words ahead of the payload
`define COMP_HDR_WORDS 8

// header word positions of the captured fields
`define COMP_HDR_FLAG_IDX 4
`define COMP_HDR_LEN_IDX 5
`define COMP_HDR_TASK_IDX 6

// buffer depths
`define COMP_BEAT_FIFO_DEPTH 4
`define COMP_INFO_FIFO_DEPTH 2

`endif

//--- hw/ll_pkg.sv
`include "comp_macros.svh"

package ll_pkg;

   // rem code, a 1 marks an invalid low byte
   typedef logic [3:0] ll_rem_t;

   localparam ll_rem_t REM_4B = 4'b0000;
   localparam ll_rem_t REM_3B = 4'b0001;
   localparam ll_rem_t REM_2B = 4'b0011;
   localparam ll_rem_t REM_1B = 4'b0111;

   // one stream word
   typedef struct packed {
      logic [`COMP_WORD_W-1:0] data;
      ll_rem_t                 rem;
      logic                    sof;
      logic                    eof;
   } ll_word_t;

endpackage

//--- hw/comp_pkg.sv
`include "comp_macros.svh"

package comp_pkg;

   // operation flags as carried in header word bits 31:29
   typedef struct packed {
      logic comp;
      logic decomp;
      logic copy;
   } op_flags_t;

   // two payload words, first word in hi
   typedef struct packed {
      logic [`COMP_WORD_W-1:0] hi;
      logic [`COMP_WORD_W-1:0] lo;
      logic                    last;
   } pair_beat_t;

   // fields captured from the header
   typedef struct packed {
      op_flags_t               flags;
      logic [`COMP_WORD_W-1:0] src_len;
      logic [9:0]              task_idx;
   } frame_info_t;

endpackage

//--- hw/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
   parameter type item_t = logic,
   parameter int  DEPTH  = 4
) (
   input  logic  clk,
   input  logic  rst_n,
   input  item_t push_i,
   input  logic  push_valid_i,
   output logic  push_ready_o,
   output item_t pop_o,
   output logic  pop_valid_o,
   input  logic  pop_ready_i
);
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   item_t            mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push_fire;
   logic             pop_fire;

   // wrap for depths that are not a power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign push_ready_o = (count != CNT_W'(DEPTH));
   assign pop_valid_o  = (count != '0);
   assign pop_o        = mem[rd_ptr];
   assign push_fire    = push_valid_i && push_ready_o;
   assign pop_fire     = pop_valid_o && pop_ready_i;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_fire) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop_fire) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         if (push_fire && !pop_fire) begin
            count <= count + 1'b1;
         end else if (pop_fire && !push_fire) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push_fire) begin
         mem[wr_ptr] <= push_i;
      end
   end

   // a full buffer without a pop keeps its count and write pointer
   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
      (count == CNT_W'(DEPTH) && !pop_fire) |=> (count == CNT_W'(DEPTH) && $stable(wr_ptr)));

   // an empty buffer without a push keeps its count and read pointer
   a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
      (count == '0 && !push_fire) |=> (count == '0 && $stable(rd_ptr)));

endmodule

//--- hw/ll_frame_parser.sv
`timescale 1ns/1ps
`include "comp_macros.svh"

module ll_frame_parser (
   input  logic                  clk,
   input  logic                  rst_n,
   input  ll_pkg::ll_word_t      in_word_i,
   input  logic                  in_valid_i,
   output logic                  in_ready_o,
   output comp_pkg::pair_beat_t  beat_o,
   output logic                  beat_valid_o,
   input  logic                  beat_ready_i,
   output comp_pkg::frame_info_t info_o,
   output logic                  info_valid_o,
   input  logic                  info_ready_i
);
   import ll_pkg::*;
   import comp_pkg::*;

   localparam int CNT_W = $clog2(`COMP_HDR_WORDS);
   localparam logic [CNT_W-1:0] HDR_LAST = CNT_W'(`COMP_HDR_WORDS - 1);

   logic                    in_hdr;
   logic [CNT_W-1:0]        hdr_cnt;
   logic                    slot_lo;
   logic                    in_fire;
   logic [`COMP_WORD_W-1:0] word_data;
   logic [`COMP_WORD_W-1:0] hi_q;
   pair_beat_t              beat_q;
   logic                    beat_valid_q;
   frame_info_t             info_q;
   logic                    info_valid_q;

   function automatic logic [`COMP_WORD_W-1:0] mask_word(input logic [`COMP_WORD_W-1:0] data,
                                                         input ll_rem_t rem);
      logic [`COMP_WORD_W-1:0] res;
      res = data;
      case (rem)
         REM_3B:  res = {data[`COMP_WORD_W-1:8], 8'h00};
         REM_2B:  res = {data[`COMP_WORD_W-1:16], 16'h0000};
         REM_1B:  res = {data[`COMP_WORD_W-1:24], 24'h000000};
         default: res = data;
      endcase
      return res;
   endfunction

   // stall while a finished beat or info has not been taken
   assign in_ready_o = !(beat_valid_q && !beat_ready_i) && !(info_valid_q && !info_ready_i);
   assign in_fire    = in_valid_i && in_ready_o;
   assign word_data  = in_word_i.eof ? mask_word(in_word_i.data, in_word_i.rem) : in_word_i.data;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_hdr       <= 1'b1;
         hdr_cnt      <= '0;
         slot_lo      <= 1'b0;
         beat_valid_q <= 1'b0;
         info_valid_q <= 1'b0;
      end else begin
         if (beat_valid_q && beat_ready_i) begin
            beat_valid_q <= 1'b0;
         end
         if (info_valid_q && info_ready_i) begin
            info_valid_q <= 1'b0;
         end
         if (in_fire && in_hdr) begin
            // idle until sof starts a header
            if (hdr_cnt != '0 || in_word_i.sof) begin
               if (hdr_cnt == HDR_LAST) begin
                  in_hdr       <= 1'b0;
                  hdr_cnt      <= '0;
                  slot_lo      <= 1'b0;
                  info_valid_q <= 1'b1;
               end else begin
                  hdr_cnt <= hdr_cnt + 1'b1;
               end
            end
         end else if (in_fire) begin
            if (slot_lo || in_word_i.eof) begin
               beat_valid_q <= 1'b1;
            end
            slot_lo <= !slot_lo && !in_word_i.eof;
            if (in_word_i.eof) begin
               in_hdr <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (in_fire && in_hdr) begin
         if (hdr_cnt == CNT_W'(`COMP_HDR_FLAG_IDX)) begin
            info_q.flags <= op_flags_t'(in_word_i.data[31:29]);
         end
         if (hdr_cnt == CNT_W'(`COMP_HDR_LEN_IDX)) begin
            info_q.src_len <= in_word_i.data;
         end
         if (hdr_cnt == CNT_W'(`COMP_HDR_TASK_IDX)) begin
            info_q.task_idx <= in_word_i.data[9:0];
         end
      end else if (in_fire) begin
         if (!slot_lo) begin
            hi_q <= word_data;
         end
         // odd word count, lo stays zero
         if (!slot_lo && in_word_i.eof) begin
            beat_q.hi   <= word_data;
            beat_q.lo   <= '0;
            beat_q.last <= 1'b1;
         end else if (slot_lo) begin
            beat_q.hi   <= hi_q;
            beat_q.lo   <= word_data;
            beat_q.last <= in_word_i.eof;
         end
      end
   end

   assign beat_o       = beat_q;
   assign beat_valid_o = beat_valid_q;
   assign info_o       = info_q;
   assign info_valid_o = info_valid_q;

   a_sof_at_hdr0: assert property (@(posedge clk) disable iff (!rst_n)
      (in_fire && in_word_i.sof) |-> (in_hdr && hdr_cnt == '0));

   a_no_eof_in_hdr: assert property (@(posedge clk) disable iff (!rst_n)
      (in_fire && in_word_i.eof) |-> !in_hdr);

endmodule

//--- hw/ll_frame_builder.sv
`timescale 1ns/1ps
`include "comp_macros.svh"

module ll_frame_builder (
   input  logic                  clk,
   input  logic                  rst_n,
   input  comp_pkg::pair_beat_t  beat_i,
   input  logic                  beat_valid_i,
   output logic                  beat_ready_o,
   input  comp_pkg::frame_info_t info_i,
   input  logic                  info_valid_i,
   output logic                  info_ready_o,
   output ll_pkg::ll_word_t      out_word_o,
   output logic                  out_valid_o,
   input  logic                  out_ready_i
);
   import ll_pkg::*;
   import comp_pkg::*;

   typedef enum logic [2:0] {
      S_HI,
      S_LO,
      S_STATUS,
      S_LENGTH,
      S_TASK
   } state_t;

   state_t                  state;
   ll_word_t                out_q;
   logic                    out_valid_q;
   logic                    out_free;
   logic                    pop_beat;
   logic                    pop_info;
   logic                    load;
   logic [15:0]             beat_cnt;
   logic                    first_q;
   logic [`COMP_WORD_W-1:0] lo_q;
   logic                    last_q;
   frame_info_t             info_q;
   logic                    status_ok;

   assign out_free     = !out_valid_q || out_ready_i;
   assign beat_ready_o = (state == S_HI) && out_free;
   assign info_ready_o = (state == S_STATUS) && out_free;
   assign pop_beat     = beat_ready_o && beat_valid_i;
   assign pop_info     = info_ready_o && info_valid_i;
   assign load         = pop_beat || pop_info ||
                         (out_free && (state == S_LO || state == S_LENGTH || state == S_TASK));

   // beats seen against the length field in 8-byte units
   assign status_ok = (beat_cnt == info_i.src_len[18:3]);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state       <= S_HI;
         out_valid_q <= 1'b0;
         beat_cnt    <= '0;
         first_q     <= 1'b1;
      end else begin
         if (load) begin
            out_valid_q <= 1'b1;
         end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
         end
         case (state)
            S_HI: begin
               if (pop_beat) begin
                  state    <= S_LO;
                  beat_cnt <= beat_cnt + 1'b1;
                  first_q  <= 1'b0;
               end
            end
            S_LO: begin
               if (out_free) begin
                  state <= last_q ? S_STATUS : S_HI;
               end
            end
            S_STATUS: begin
               if (pop_info) begin
                  state <= S_LENGTH;
               end
            end
            S_LENGTH: begin
               if (out_free) begin
                  state <= S_TASK;
               end
            end
            S_TASK: begin
               if (out_free) begin
                  state    <= S_HI;
                  beat_cnt <= '0;
                  first_q  <= 1'b1;
               end
            end
            default: state <= S_HI;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (pop_beat) begin
         lo_q   <= beat_i.lo;
         last_q <= beat_i.last;
      end
      if (pop_info) begin
         info_q <= info_i;
      end
      if (load) begin
         out_q.rem <= REM_4B;
         out_q.sof <= 1'b0;
         out_q.eof <= 1'b0;
         case (state)
            S_HI: begin
               out_q.data <= beat_i.hi;
               out_q.sof  <= first_q;
            end
            S_LO:     out_q.data <= lo_q;
            S_STATUS: out_q.data <= {info_i.flags, status_ok, {(`COMP_WORD_W-4){1'b0}}};
            S_LENGTH: out_q.data <= {{(`COMP_WORD_W-19){1'b0}}, beat_cnt, 3'b000};
            S_TASK: begin
               out_q.data <= {{(`COMP_WORD_W-10){1'b0}}, info_q.task_idx};
               out_q.eof  <= 1'b1;
            end
            default: out_q.data <= '0;
         endcase
      end
   end

   assign out_word_o  = out_q;
   assign out_valid_o = out_valid_q;

   // parser pushes info at header word 7, ahead of every beat
   a_info_ready_for_footer: assert property (@(posedge clk) disable iff (!rst_n)
      (state == S_STATUS) |-> info_valid_i);

endmodule

//--- hw/comp_unit.sv
`timescale 1ns/1ps
`include "comp_macros.svh"

module comp_unit (
   input  logic             clk,
   input  logic             rst_n,
   input  ll_pkg::ll_word_t in_word_i,
   input  logic             in_valid_i,
   output logic             in_ready_o,
   output ll_pkg::ll_word_t out_word_o,
   output logic             out_valid_o,
   input  logic             out_ready_i
);
   import comp_pkg::*;

   pair_beat_t  beat_push;
   logic        beat_push_valid;
   logic        beat_push_ready;
   pair_beat_t  beat_pop;
   logic        beat_pop_valid;
   logic        beat_pop_ready;
   frame_info_t info_push;
   logic        info_push_valid;
   logic        info_push_ready;
   frame_info_t info_pop;
   logic        info_pop_valid;
   logic        info_pop_ready;

   ll_frame_parser u_parser (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_word_i    (in_word_i),
      .in_valid_i   (in_valid_i),
      .in_ready_o   (in_ready_o),
      .beat_o       (beat_push),
      .beat_valid_o (beat_push_valid),
      .beat_ready_i (beat_push_ready),
      .info_o       (info_push),
      .info_valid_o (info_push_valid),
      .info_ready_i (info_push_ready)
   );

   // payload beats
   sync_fifo #(
      .item_t (pair_beat_t),
      .DEPTH  (`COMP_BEAT_FIFO_DEPTH)
   ) u_beat_fifo (
      .clk          (clk),
      .rst_n        (rst_n),
      .push_i       (beat_push),
      .push_valid_i (beat_push_valid),
      .push_ready_o (beat_push_ready),
      .pop_o        (beat_pop),
      .pop_valid_o  (beat_pop_valid),
      .pop_ready_i  (beat_pop_ready)
   );

   // one entry per frame in flight
   sync_fifo #(
      .item_t (frame_info_t),
      .DEPTH  (`COMP_INFO_FIFO_DEPTH)
   ) u_info_fifo (
      .clk          (clk),
      .rst_n        (rst_n),
      .push_i       (info_push),
      .push_valid_i (info_push_valid),
      .push_ready_o (info_push_ready),
      .pop_o        (info_pop),
      .pop_valid_o  (info_pop_valid),
      .pop_ready_i  (info_pop_ready)
   );

   ll_frame_builder u_builder (
      .clk          (clk),
      .rst_n        (rst_n),
      .beat_i       (beat_pop),
      .beat_valid_i (beat_pop_valid),
      .beat_ready_o (beat_pop_ready),
      .info_i       (info_pop),
      .info_valid_i (info_pop_valid),
      .info_ready_o (info_pop_ready),
      .out_word_o   (out_word_o),
      .out_valid_o  (out_valid_o),
      .out_ready_i  (out_ready_i)
   );

endmodule

//--- tests/comp_ref_model.svh
`ifndef COMP_REF_MODEL_SVH
`define COMP_REF_MODEL_SVH

// expected output words of one frame, appended to exp_q
// payload comes from gen_payload

// bytes that rem marks invalid are cleared from the low end
function automatic logic [31:0] last_word_data(input logic [31:0] data, input logic [3:0] rem);
   logic [31:0] keep;
   int          dropped;
   int          b;
   case (rem)
      REM_3B:  dropped = 1;
      REM_2B:  dropped = 2;
      REM_1B:  dropped = 3;
      default: dropped = 0;
   endcase
   keep = '1;
   for (b = 0; b < dropped; b++) begin
      keep[b*8 +: 8] = 8'h00;
   end
   return data & keep;
endfunction

task automatic push_expected(input logic [31:0] data, input logic sof, input logic eof);
   ll_word_t w;
   w.data = data;
   w.rem  = REM_4B;
   w.sof  = sof;
   w.eof  = eof;
   exp_q.push_back(w);
endtask

task automatic expect_frame(input logic [2:0] flags, input logic [31:0] src_len,
                            input logic [9:0] task_idx, input logic [3:0] rem);
   int          n_words;
   int          n_beats;
   int          i;
   logic [31:0] data;
   logic        len_ok;
   n_words = gen_payload.size();
   n_beats = (n_words + 1) / 2;
   for (i = 0; i < n_words; i++) begin
      data = gen_payload[i];
      if (i == n_words - 1) begin
         data = last_word_data(data, rem);
      end
      push_expected(data, i == 0, 1'b0);
   end
   // odd count, the last beat carries a zero lo word
   if (n_words % 2 == 1) begin
      push_expected(32'h0, 1'b0, 1'b0);
   end
   len_ok = (src_len[18:3] == 16'(n_beats));
   push_expected({flags, len_ok, 28'h0}, 1'b0, 1'b0);
   push_expected(32'(n_beats * 8), 1'b0, 1'b0);
   push_expected({22'h0, task_idx}, 1'b0, 1'b1);
endtask

`endif

//--- tests/tb_comp_unit.sv
`timescale 1ns/1ps
`include "comp_macros.svh"

module tb_comp_unit;
   import ll_pkg::*;

   localparam int NUM_FRAMES = 20;
   // 20 frames x 26 words x 4 for stalls is 2080, rounded up
   localparam int MAX_CYCLES = 4000;

   logic        clk;
   logic        rst_n;
   ll_word_t    in_word_i;
   logic        in_valid_i;
   logic        in_ready_o;
   ll_word_t    out_word_o;
   logic        out_valid_o;
   logic        out_ready_i;

   integer      seed;
   int          cycles;
   int          frames_seen;
   int          stall_left;
   int          in_idx;
   logic        in_fire_next;
   ll_word_t    in_q[$];
   ll_word_t    exp_q[$];
   logic [31:0] gen_payload[$];

   `include "comp_ref_model.svh"

   comp_unit dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_word_i   (in_word_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .out_word_o  (out_word_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: only %0d of %0d frames came out after %0d cycles",
                  frames_seen, NUM_FRAMES, cycles);
         $display("Simulation finished: FAIL");
         $fatal(1, "timeout");
      end
   end

   task automatic report_fail();
      $display("Simulation finished: FAIL");
      $fatal(1, "check failed");
   endtask

   task automatic queue_input_frame(input logic [2:0] flags, input logic [31:0] src_len,
                                    input logic [9:0] task_idx, input logic [3:0] rem);
      ll_word_t w;
      int       i;
      for (i = 0; i < `COMP_HDR_WORDS; i++) begin
         w      = '0;
         w.data = $random(seed);
         w.sof  = (i == 0);
         if (i == `COMP_HDR_FLAG_IDX) w.data[31:29] = flags;
         if (i == `COMP_HDR_LEN_IDX) w.data = src_len;
         if (i == `COMP_HDR_TASK_IDX) w.data[9:0] = task_idx;
         in_q.push_back(w);
      end
      for (i = 0; i < gen_payload.size(); i++) begin
         w      = '0;
         w.data = gen_payload[i];
         w.eof  = (i == gen_payload.size() - 1);
         if (w.eof) w.rem = rem;
         in_q.push_back(w);
      end
   endtask

   task automatic build_frames();
      logic [2:0]  flags;
      logic [31:0] src_len;
      logic [9:0]  task_idx;
      logic [3:0]  rem;
      int          n_words;
      int          f;
      int          i;
      for (f = 0; f < NUM_FRAMES; f++) begin
         flags    = 3'($random(seed));
         task_idx = 10'($random(seed));
         n_words  = 1 + int'($unsigned($random(seed)) % 15);
         src_len  = $random(seed);
         // even frames carry a length that matches the beat count
         if (f % 2 == 0) src_len[18:3] = 16'((n_words + 1) / 2);
         case ($unsigned($random(seed)) % 5)
            0:       rem = REM_4B;
            1:       rem = REM_3B;
            2:       rem = REM_2B;
            3:       rem = REM_1B;
            default: rem = 4'($random(seed));
         endcase
         gen_payload.delete();
         for (i = 0; i < n_words; i++) begin
            gen_payload.push_back($random(seed));
         end
         queue_input_frame(flags, src_len, task_idx, rem);
         expect_frame(flags, src_len, task_idx, rem);
      end
   endtask

   task automatic check_output(input ll_word_t got);
      ll_word_t exp;
      assert (exp_q.size() > 0) else begin
         $display("Unexpected output word %h after all expected words were seen", got.data);
         report_fail();
      end
      exp = exp_q.pop_front();
      assert (got.data == exp.data) else begin
         $display("Mismatch out_word_o.data: expected %h, got %h", exp.data, got.data);
         report_fail();
      end
      assert (got.rem == exp.rem) else begin
         $display("Mismatch out_word_o.rem: expected %h, got %h", exp.rem, got.rem);
         report_fail();
      end
      assert (got.sof == exp.sof) else begin
         $display("Mismatch out_word_o.sof: expected %h, got %h", exp.sof, got.sof);
         report_fail();
      end
      assert (got.eof == exp.eof) else begin
         $display("Mismatch out_word_o.eof: expected %h, got %h", exp.eof, got.eof);
         report_fail();
      end
      if (got.eof) frames_seen++;
   endtask

   initial begin
      seed         = 58;
      clk          = 1'b0;
      rst_n        = 1'b0;
      in_word_i    = '0;
      in_valid_i   = 1'b0;
      out_ready_i  = 1'b0;
      cycles       = 0;
      frames_seen  = 0;
      stall_left   = 0;
      in_idx       = 0;
      in_fire_next = 1'b0;
      build_frames();
      repeat (3) @(negedge clk);
      rst_n = 1'b1;

      // idle after reset
      repeat (4) begin
         @(negedge clk);
         assert (!out_valid_o) else begin
            $display("Mismatch out_valid_o: expected %h, got %h", 1'b0, out_valid_o);
            report_fail();
         end
         assert (in_ready_o) else begin
            $display("Mismatch in_ready_o: expected %h, got %h", 1'b1, in_ready_o);
            report_fail();
         end
      end

      // a word offered at a falling edge transfers at the next rising edge
      while (frames_seen < NUM_FRAMES) begin
         @(negedge clk);
         if (in_fire_next) in_idx++;
         if (!(in_valid_i && !in_fire_next)) begin
            if (in_idx < in_q.size() && ($random(seed) & 3) != 0) begin
               in_word_i  = in_q[in_idx];
               in_valid_i = 1'b1;
            end else begin
               in_valid_i = 1'b0;
            end
         end
         in_fire_next = in_valid_i && in_ready_o;

         if (stall_left > 0) begin
            stall_left--;
            out_ready_i = 1'b0;
         end else if (($random(seed) & 31) == 0) begin
            // long stall, lets the beat FIFO fill
            stall_left  = 4 + int'($unsigned($random(seed)) % 16);
            out_ready_i = 1'b0;
         end else begin
            out_ready_i = ($random(seed) & 3) != 0;
         end
         if (out_valid_o && out_ready_i) check_output(out_word_o);
      end

      @(negedge clk);
      out_ready_i = 1'b0;
      in_valid_i  = 1'b0;
      if (exp_q.size() == 0 && in_idx == in_q.size()) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         $display("Run ended with %0d expected words left and %0d input words unsent",
                  exp_q.size(), in_q.size() - in_idx);
         report_fail();
      end
   end

endmodule

//--- sim.f
+incdir+hw
+incdir+tests
hw/ll_pkg.sv
hw/comp_pkg.sv
hw/sync_fifo.sv
hw/ll_frame_parser.sv
hw/ll_frame_builder.sv
hw/comp_unit.sv
tests/tb_comp_unit.sv

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator, result taken from the simulation log
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module tb_comp_unit -f sim.f \
   > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_comp_unit > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "test failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "test did not complete"; exit 1; }
echo "test passed"
exit 0
